/* verification/ulpb_patterns.mem */
// src dst data src2 data2 ack, all hex
// src2 of f means a single requester, both messages go to dst
0 a1 12345678 f 00000000 1
0 a2 deadbeef f 00000000 1
1 a0 a5a5a5a5 f 00000000 1
1 a2 00000001 f 00000000 1
2 a0 80000000 f 00000000 1
2 a1 ffffffff f 00000000 1
0 b3 cafef00d f 00000000 0
2 a3 0badc0de f 00000000 0
0 a2 11111111 1 22222222 1
0 a1 33333333 2 44444444 1
1 a0 55555555 2 66666666 1
2 a1 77777777 0 88888888 1
1 a0 00000000 f 00000000 1
0 7f 13579bdf 2 2468ace0 0
2 a0 fedcba98 f 00000000 1
1 a2 5a5a5a5a 0 c3c3c3c3 1

/* ulpb_ring.f */
+incdir+src
src/ulpb_pkg.sv
src/ulpb_node.sv
src/ulpb_mediator.sv
src/ulpb_ring.sv
verification/ulpb_ring_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 -Wno-fatal --top-module ulpb_ring_tb -f ulpb_ring.f -o ulpb_sim

./obj_dir/ulpb_sim > sim.log
cat sim.log

if grep -q "Regression failed" sim.log
then
	echo "simulation reported errors, see sim.log"
	exit 1
fi

echo "simulation clean"

/* verification/ulpb_ring_tb.sv */
`timescale 1ns/1ps
`include "ulpb_defs.svh"

module ulpb_ring_tb;
	import ulpb_pkg::*;

	localparam int NUM_TESTS = 16;
	localparam int WORDS = 6;	// Fields per pattern line
	localparam int TRANS_CYCLES = 172;
	localparam int CYCLE_LIMIT = NUM_TESTS * 2 * TRANS_CYCLES + 200;
	localparam int RX_WAIT = 0;
	localparam int RX_HOLD = 1;
	localparam int RX_RELEASE = 2;
	localparam int RX_DONE = 3;

	logic CLK = 1'b0;
	logic RESET = 1'b0;
	ulpb_msg_t [`ULPB_NUM_NODES-1:0] tx_msg = '0;
	logic [`ULPB_NUM_NODES-1:0] req_tx = '0;
	logic [`ULPB_NUM_NODES-1:0] ack_tx;
	ulpb_msg_t [`ULPB_NUM_NODES-1:0] rx_msg;
	logic [`ULPB_NUM_NODES-1:0] req_rx;
	logic [`ULPB_NUM_NODES-1:0] ack_rx = '0;
	logic [`ULPB_NUM_NODES-1:0] ack_received;
	logic bus_active;

	logic [31:0] pat_mem [0:NUM_TESTS*WORDS-1];
	logic active_seen = 1'b0;	// bus_active at the last rising edge
	int cycle_cnt = 0;
	int err_cnt = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	integer seed = 60504;

	ulpb_ring dut (
		.CLK(CLK),
		.RESET(RESET),
		.tx_msg(tx_msg),
		.req_tx(req_tx),
		.ack_tx(ack_tx),
		.rx_msg(rx_msg),
		.req_rx(req_rx),
		.ack_rx(ack_rx),
		.ack_received(ack_received),
		.bus_active(bus_active)
	);

	always
	begin
		#20 CLK = ~CLK;
	end

	always @(posedge CLK)
	begin
		active_seen <= bus_active;
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic check(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			err_cnt++;
		end
	endtask

	task automatic report_test(input int num, input int errs_before);
		if (err_cnt == errs_before)
		begin
			$display("test %0d ok", num);
			pass_cnt++;
		end
		else
		begin
			$display("test %0d failed with %0d errors", num, err_cnt - errs_before);
			fail_cnt++;
		end
	endtask

	// Follows one transaction of src until the bus stops and the receiver is released
	task automatic run_transfer(input int src, input int loser, input ulpb_addr_t dst,
		input ulpb_data_t data, input logic exp_ack);
		int dst_node;
		int rx_state;
		int delay;
		logic ended;
		logic busy;
		logic ack_seen;
		logic loser_ack;
		logic [`ULPB_NUM_NODES-1:0] dst_mask;
		logic [`ULPB_NUM_NODES-1:0] stray_rx;
		ulpb_msg_t exp_msg;

		dst_node = int'(dst) - int'(`ULPB_ADDR_BASE);
		if ((dst_node < 0) || (dst_node >= `ULPB_NUM_NODES))
			dst_node = -1;	// Nobody answers
		dst_mask = '0;
		if (dst_node >= 0)
			dst_mask[dst_node] = 1'b1;
		exp_msg.addr = dst;
		exp_msg.data = data;
		rx_state = RX_WAIT;
		delay = 0;
		ended = 1'b0;
		busy = 1'b1;
		ack_seen = 1'b0;
		loser_ack = 1'b0;
		stray_rx = '0;

		while (!active_seen)
			@(negedge CLK);
		while (busy)
		begin
			if (!ended)
			begin
				if (ack_tx[src])
				begin
					ack_seen = 1'b1;
					req_tx[src] <= 1'b0;
				end
				if (loser >= 0)
					loser_ack = loser_ack | ack_tx[loser];
				if (!active_seen)
				begin
					ended = 1'b1;
					check($sformatf("ack_received[%0d]", src), ack_received[src], exp_ack);
					check($sformatf("ack_tx[%0d]", src), ack_tx[src], 0);
				end
			end
			stray_rx = stray_rx | (req_rx & ~dst_mask);
			case (rx_state)
				RX_WAIT:
				begin
					if ((dst_node >= 0) && req_rx[dst_node])
					begin
						check($sformatf("rx_msg[%0d]", dst_node), rx_msg[dst_node], exp_msg);
						delay = $unsigned($random(seed)) % 4;
						rx_state = RX_HOLD;
					end
				end
				RX_HOLD:
				begin
					check($sformatf("req_rx[%0d]", dst_node), req_rx[dst_node], 1);
					check($sformatf("rx_msg[%0d]", dst_node), rx_msg[dst_node], exp_msg);
					if (delay == 0)
					begin
						ack_rx[dst_node] <= 1'b1;
						rx_state = RX_RELEASE;
					end
					else
					begin
						delay--;
					end
				end
				RX_RELEASE:
				begin
					if (!req_rx[dst_node])
					begin
						ack_rx[dst_node] <= 1'b0;
						rx_state = RX_DONE;
					end
				end
				default:
				begin
				end
			endcase
			busy = !ended || (rx_state == RX_HOLD) || (rx_state == RX_RELEASE);
			if (busy)
				@(negedge CLK);
		end
		check($sformatf("ack_tx[%0d] raised", src), ack_seen, 1);
		if (loser >= 0)
			check($sformatf("ack_tx[%0d] while waiting", loser), loser_ack, 0);
		check("req_rx of other nodes", stray_rx, 0);
		if ((dst_node >= 0) && (rx_state == RX_WAIT))
		begin
			$display("error at %0t: message for node %0d was never delivered", $time, dst_node);
			err_cnt++;
		end
	endtask

	task automatic run_pattern(input int idx);
		int base;
		int src;
		int src2;
		int errs_before;
		ulpb_addr_t dst;
		ulpb_data_t data;
		ulpb_data_t data2;
		logic exp_ack;

		base = idx * WORDS;
		src = int'(pat_mem[base]);
		dst = ulpb_addr_t'(pat_mem[base+1]);
		data = pat_mem[base+2];
		src2 = int'(pat_mem[base+3]);
		data2 = pat_mem[base+4];
		exp_ack = pat_mem[base+5][0];
		errs_before = err_cnt;
		if (src2 >= `ULPB_NUM_NODES)
			src2 = -1;	// Single requester

		@(negedge CLK);
		tx_msg[src] <= {dst, data};
		req_tx[src] <= 1'b1;
		if (src2 >= 0)
		begin
			tx_msg[src2] <= {dst, data2};
			req_tx[src2] <= 1'b1;
		end

		// Lower index is nearer the mediator and goes first
		if ((src2 >= 0) && (src2 < src))
		begin
			run_transfer(src2, src, dst, data2, exp_ack);
			run_transfer(src, -1, dst, data, exp_ack);
		end
		else if (src2 >= 0)
		begin
			run_transfer(src, src2, dst, data, exp_ack);
			run_transfer(src2, -1, dst, data2, exp_ack);
		end
		else
		begin
			run_transfer(src, -1, dst, data, exp_ack);
		end
		report_test(idx + 1, errs_before);
	endtask

	initial
	begin
		int errs_before;

		$readmemh("verification/ulpb_patterns.mem", pat_mem);
		repeat (2) @(negedge CLK);
		RESET <= 1'b1;
		@(negedge CLK);
		errs_before = err_cnt;
		check("bus_active", bus_active, 0);
		check("ack_tx", ack_tx, 0);
		check("req_rx", req_rx, 0);
		check("ack_received", ack_received, 0);
		for (int n = 0; n < `ULPB_NUM_NODES; n++)
			check($sformatf("rx_msg[%0d]", n), rx_msg[n], 0);
		report_test(0, errs_before);

		for (int t = 0; t < NUM_TESTS; t++)
			run_pattern(t);

		$display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if ((err_cnt == 0) && (fail_cnt == 0))
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* src/ulpb_ring.sv */
`timescale 1ns/1ps
`include "ulpb_defs.svh"

module ulpb_ring (
	input logic CLK,
	input logic RESET,
	input ulpb_pkg::ulpb_msg_t [`ULPB_NUM_NODES-1:0] tx_msg,
	input logic [`ULPB_NUM_NODES-1:0] req_tx,
	output logic [`ULPB_NUM_NODES-1:0] ack_tx,
	output ulpb_pkg::ulpb_msg_t [`ULPB_NUM_NODES-1:0] rx_msg,
	output logic [`ULPB_NUM_NODES-1:0] req_rx,
	input logic [`ULPB_NUM_NODES-1:0] ack_rx,
	output logic [`ULPB_NUM_NODES-1:0] ack_received,
	output logic bus_active
);
	import ulpb_pkg::*;

	logic bus_clk;
	logic [`ULPB_NUM_NODES:0] ring;	// ring[i] feeds node i

	ulpb_mediator u_mediator (
		.CLK(CLK),
		.RESET(RESET),
		.ring_in(ring[`ULPB_NUM_NODES]),
		.ring_out(ring[0]),
		.bus_clk(bus_clk),
		.bus_active(bus_active)
	);

	// Node 0 sits right after the mediator and wins ties
	for (genvar i = 0; i < `ULPB_NUM_NODES; i++)
	begin : g_node
		ulpb_node #(
			.NODE_ADDR(ulpb_addr_t'(`ULPB_ADDR_BASE + i))
		) u_node (
			.CLK(bus_clk),
			.RESET(RESET),
			.din(ring[i]),
			.dout(ring[i+1]),
			.tx_msg(tx_msg[i]),
			.req_tx(req_tx[i]),
			.ack_tx(ack_tx[i]),
			.rx_msg(rx_msg[i]),
			.req_rx(req_rx[i]),
			.ack_rx(ack_rx[i]),
			.ack_received(ack_received[i])
		);
	end

endmodule

/* src/ulpb_mediator.sv */
`timescale 1ns/1ps
`include "ulpb_defs.svh"

module ulpb_mediator #(
	parameter int RESET_CNT = `ULPB_RESET_CNT
) (
	input logic CLK,
	input logic RESET,
	input logic ring_in,
	output logic ring_out,
	output logic bus_clk,
	output logic bus_active
);
	import ulpb_pkg::*;

	localparam int RST_W = $clog2(RESET_CNT + 1);
	localparam logic [RST_W-1:0] RST_LOAD = RST_W'(RESET_CNT - 1);

	ulpb_phase_e phase;
	logic [RST_W-1:0] rst_cnt;
	logic [1:0] samp;
	logic toggle_seen;	// End toggle round has passed
	logic tr_done;
	logic clk_en;

	assign bus_clk = CLK & clk_en;	// Enable only moves while CLK is low
	assign bus_active = clk_en;
	assign ring_out = (phase == ph_idle) ? 1'b1 : ring_in;

	always_ff @(negedge CLK or negedge RESET)
	begin
		if (!RESET)
			clk_en <= 1'b0;
		else if (!clk_en)
			clk_en <= !ring_in;	// Some node pulls low
		else if ((phase == ph_idle) && tr_done)
			clk_en <= 1'b0;
	end

	// Phase tracking, one step per bus clock
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			phase <= ph_idle;
			rst_cnt <= '0;
			samp <= '0;
			toggle_seen <= 1'b0;
			tr_done <= 1'b0;
		end
		else if (!clk_en)
		begin
			tr_done <= 1'b0;
		end
		else
		begin
			case (phase)
				ph_idle:
				begin
					phase <= ph_arb;
					toggle_seen <= 1'b0;
				end
				ph_arb: phase <= ph_drive1;
				ph_drive1:
				begin
					phase <= ph_latch1;
					samp <= {samp[0], ring_in};
				end
				ph_latch1: phase <= ph_drive2;
				ph_drive2:
				begin
					phase <= ph_latch2;
					samp <= {samp[0], ring_in};
				end
				ph_latch2:
				begin
					rst_cnt <= RST_LOAD;
					if (toggle_seen)
						phase <= ph_reset;	// Acknowledge round is over
					else
					begin
						phase <= ph_drive1;
						if (samp[1] ^ samp[0])
							toggle_seen <= 1'b1;
					end
				end
				default:
				begin
					if (rst_cnt == '0)
					begin
						phase <= ph_idle;
						tr_done <= 1'b1;
					end
					else
						rst_cnt <= rst_cnt - 1'b1;
				end
			endcase
		end
	end

endmodule

/* src/ulpb_node.sv */
`timescale 1ns/1ps
`include "ulpb_defs.svh"

module ulpb_node #(
	parameter ulpb_pkg::ulpb_addr_t NODE_ADDR = `ULPB_ADDR_BASE,
	parameter int RESET_CNT = `ULPB_RESET_CNT
) (
	input logic CLK,
	input logic RESET,
	input logic din,
	output logic dout,
	input ulpb_pkg::ulpb_msg_t tx_msg,
	input logic req_tx,
	output logic ack_tx,
	output ulpb_pkg::ulpb_msg_t rx_msg,
	output logic req_rx,
	input logic ack_rx,
	output logic ack_received
);
	import ulpb_pkg::*;

	localparam int MSG_BITS = `ULPB_ADDR_WIDTH + `ULPB_DATA_WIDTH;
	localparam int CNT_W = $clog2(MSG_BITS + 1);
	localparam int RST_W = $clog2(RESET_CNT + 1);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(MSG_BITS - 1);
	localparam logic [CNT_W-1:0] ADDR_BITS = CNT_W'(`ULPB_ADDR_WIDTH);
	localparam logic [RST_W-1:0] RST_LOAD = RST_W'(RESET_CNT - 1);

	ulpb_phase_e phase;
	ulpb_mode_e mode;
	logic [CNT_W-1:0] bit_cnt;	// Bits sent or received
	logic [RST_W-1:0] rst_cnt;
	logic [1:0] samp;	// Drive 1 and drive 2 samples
	logic out_reg;
	logic bits_done;	// Transmitter is in its end toggle round
	logic ack_round;	// Final round of the message
	ulpb_msg_t tx_sr;
	ulpb_msg_t rx_sr;

	logic request;
	logic win;
	logic toggle;
	logic addr_miss;
	logic tx_shift;
	logic rx_shift;
	logic rx_deliver;

	// No new request while the last one is still acknowledged
	assign request = req_tx & ~ack_tx;
	assign win = request & din;
	assign toggle = samp[1] ^ samp[0];
	assign addr_miss = (rx_sr[`ULPB_ADDR_WIDTH-1:0] != NODE_ADDR);

	assign tx_shift = (mode == mode_tx) && ((phase == ph_arb) || (phase == ph_latch2));
	assign rx_shift = (mode == mode_rx) && (phase == ph_latch2) && !ack_round && !toggle;
	assign rx_deliver = (mode == mode_rx) && (phase == ph_latch2) && !ack_round && toggle;

	// Ring output
	always_comb
	begin
		case (phase)
			ph_idle:
			begin
				dout = din & ~request;	// Requesters pull low
			end

			ph_arb:
			begin
				if (mode == mode_tx)
					dout = 1'b0;
				else
					dout = din;
			end

			ph_reset:
			begin
				dout = 1'b1;
			end

			default:
			begin
				case (mode)
					mode_tx:
					begin
						dout = out_reg;	// Breaks the ring during the message
					end

					mode_rx:
					begin
						if (ack_round)
							dout = out_reg;
						else
							dout = din;
					end

					default:
					begin
						dout = din;
					end
				endcase
			end
		endcase
	end

	// Phase sequence and role
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			phase <= ph_idle;
			mode <= mode_idle;
			bit_cnt <= '0;
			rst_cnt <= '0;
			out_reg <= 1'b1;
			bits_done <= 1'b0;
			ack_round <= 1'b0;
			ack_received <= 1'b0;
		end
		else
		begin
			case (phase)
				ph_idle:
				begin
					phase <= ph_arb;
					if (win)
						mode <= mode_tx;
					else
						mode <= mode_rx;
					bit_cnt <= '0;
					bits_done <= 1'b0;
					ack_round <= 1'b0;
					ack_received <= 1'b0;
				end

				ph_arb:
				begin
					phase <= ph_drive1;
					out_reg <= tx_sr[MSG_BITS-1];	// First address bit
				end

				ph_drive1:
				begin
					phase <= ph_latch1;
					if ((mode == mode_rx) && (bit_cnt == ADDR_BITS) && addr_miss)
						mode <= mode_fwd;
				end

				ph_latch1:
				begin
					phase <= ph_drive2;
					if ((mode == mode_tx) && bits_done && !ack_round)
						out_reg <= 1'b1;	// Second half of end toggle
					if ((mode == mode_rx) && ack_round)
						out_reg <= 1'b0;	// Second half of acknowledge
				end

				ph_drive2:
				begin
					phase <= ph_latch2;
				end

				ph_latch2:
				begin
					rst_cnt <= RST_LOAD;
					if (ack_round)
					begin
						phase <= ph_reset;
						if (mode == mode_tx)
							ack_received <= toggle;
					end
					else
					begin
						phase <= ph_drive1;
						case (mode)
							mode_tx:
							begin
								if (bits_done)
								begin
									ack_round <= 1'b1;
								end
								else if (bit_cnt == LAST_BIT)
								begin
									bits_done <= 1'b1;
									out_reg <= 1'b0;
								end
								else
								begin
									out_reg <= tx_sr[MSG_BITS-1];
									bit_cnt <= bit_cnt + 1'b1;
								end
							end

							mode_rx:
							begin
								if (toggle)
								begin
									ack_round <= 1'b1;
									out_reg <= 1'b1;
								end
								else
								begin
									bit_cnt <= bit_cnt + 1'b1;
								end
							end

							default:
							begin
								if (toggle)
									ack_round <= 1'b1;	// Forward one more round
							end
						endcase
					end
				end

				default:
				begin
					if (rst_cnt == '0)
					begin
						phase <= ph_idle;
						mode <= mode_idle;
					end
					else
					begin
						rst_cnt <= rst_cnt - 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			samp <= '0;
		end
		else if ((phase == ph_drive1) || (phase == ph_drive2))
		begin
			samp <= {samp[0], din};
		end
	end

	// Message shift registers
	always_ff @(posedge CLK)
	begin
		if ((phase == ph_idle) && win)
			tx_sr <= tx_msg;
		else if (tx_shift)
			tx_sr <= {tx_sr[MSG_BITS-2:0], 1'b0};

		if (rx_shift)
			rx_sr <= {rx_sr[MSG_BITS-2:0], samp[0]};
	end

	// User handshakes
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			ack_tx <= 1'b0;
			req_rx <= 1'b0;
			rx_msg <= '0;
		end
		else
		begin
			if ((phase == ph_idle) && win)
				ack_tx <= 1'b1;
			else if (ack_tx && !req_tx)
				ack_tx <= 1'b0;

			if (rx_deliver)
			begin
				req_rx <= 1'b1;
				rx_msg <= rx_sr;
			end
			else if (req_rx && ack_rx)
			begin
				req_rx <= 1'b0;
			end
		end
	end

endmodule

/* src/ulpb_pkg.sv */
`include "ulpb_defs.svh"

package ulpb_pkg;
	typedef logic [`ULPB_ADDR_WIDTH-1:0] ulpb_addr_t;
	typedef logic [`ULPB_DATA_WIDTH-1:0] ulpb_data_t;

	typedef struct packed {
		ulpb_addr_t addr;	// Sent first
		ulpb_data_t data;
	} ulpb_msg_t;

	typedef enum logic [2:0] {
		ph_idle,
		ph_arb,		// Arbitration resolved
		ph_drive1,
		ph_latch1,
		ph_drive2,
		ph_latch2,
		ph_reset
	} ulpb_phase_e;

	typedef enum logic [1:0] {
		mode_idle,
		mode_tx,
		mode_rx,
		mode_fwd
	} ulpb_mode_e;
endpackage

/* src/ulpb_defs.svh */
`ifndef ULPB_DEFS_SVH
`define ULPB_DEFS_SVH

// Message layout
`define ULPB_ADDR_WIDTH 8
`define ULPB_DATA_WIDTH 32

`define ULPB_RESET_CNT 2	// Cycles of bus reset

// Ring population
`define ULPB_NUM_NODES 3
`define ULPB_ADDR_BASE 8'ha0	// Node i answers base plus i

`endif
